// File: src/mpb_pkg.sv
// shared definitions for the message passing buffer
// holds widths, queue depth, the bus address map and the structs
// that carry flits, bus address phases and the status word
// all modules reference it by scoped name

package mpb_pkg;

  ////////////////////////////////////////////////////////////
  // widths and sizes
  ////////////////////////////////////////////////////////////

  localparam int FLIT_W   = 32;                // flit and bus data
  localparam int ADDR_W   = 32;                // bus address
  localparam int CHANNELS = 2;                 // NoC channels
  localparam int CH_W     = $clog2(CHANNELS);  // channel index bits
  localparam int DEPTH    = 8;                 // entries per queue, power of two
  localparam int PTR_W    = $clog2(DEPTH);     // queue pointer bits
  localparam int LVL_W    = 4;                 // holds 0..DEPTH

  localparam logic [LVL_W-1:0] LVL_FULL = LVL_W'(DEPTH);

  ////////////////////////////////////////////////////////////
  // address map
  ////////////////////////////////////////////////////////////

  // each channel owns a 16 byte window, picked by CH_BIT
  localparam int CH_BIT = 4;
  localparam int OFS_W  = CH_BIT - 2;  // word offset in window

  // write pushes a flit, read pops the ingress head
  localparam logic [OFS_W-1:0] OFS_DATA = OFS_W'(0);
  // write pushes the closing flit, read returns status
  localparam logic [OFS_W-1:0] OFS_CTRL = OFS_W'(1);

  ////////////////////////////////////////////////////////////
  // structs
  ////////////////////////////////////////////////////////////

  // one NoC flit plus end of message marker
  typedef struct packed {
    logic [FLIT_W-1:0] data;
    logic              last;
  } mpb_flit_t;

  // AHB-Lite address phase as seen by one endpoint
  typedef struct packed {
    logic              sel;    // this channel addressed
    logic [ADDR_W-1:0] addr;
    logic              write;
    logic [1:0]        trans;  // HTRANS
  } mpb_ahb_req_t;

  // status word, in_level sits in the low nibble
  typedef struct packed {
    logic [FLIT_W-3*LVL_W-2:0] pad;           // always zero
    logic                      in_head_last;  // ingress head ends a message
    logic [LVL_W-1:0]          out_msgs;      // complete messages waiting
    logic [LVL_W-1:0]          out_level;
    logic [LVL_W-1:0]          in_level;
  } mpb_status_t;

endpackage

// File: src/mpb_fifo.sv
// flit queue used for both ingress and egress of a channel
// circular buffer of DEPTH flits, each with its last marker
// head is visible combinationally, pop just advances the read side
// callers must not push when full or pop when empty

`timescale 1ns/1ps

module mpb_fifo (
  input  logic                       HCLK,
  input  logic                       HRESETn,
  input  logic                       push,
  input  mpb_pkg::mpb_flit_t         push_flit,
  input  logic                       pop,
  output mpb_pkg::mpb_flit_t         head,
  output logic                       empty,
  output logic                       full,
  output logic [mpb_pkg::LVL_W-1:0]  level
);

  mpb_pkg::mpb_flit_t        mem [mpb_pkg::DEPTH];  // flit storage
  logic [mpb_pkg::PTR_W-1:0] wr_ptr;
  logic [mpb_pkg::PTR_W-1:0] rd_ptr;

  // storage write
  always_ff @(posedge HCLK) begin
    if (push) mem[wr_ptr] <= push_flit;
  end

  // pointers and fill level
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;  // wraps, depth is 2^n
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   level <= level + 1'b1;
        2'b01:   level <= level - 1'b1;
        default: ;                        // both or none, level holds
      endcase
    end
  end

  assign head  = mem[rd_ptr];
  assign empty = (level == '0);
  assign full  = (level == mpb_pkg::LVL_FULL);

  // the bus side and the NoC side both rely on the flags
  a_no_overflow : assert property (@(posedge HCLK) disable iff (!HRESETn)
    push |-> !full);
  a_no_underflow : assert property (@(posedge HCLK) disable iff (!HRESETn)
    pop |-> !empty);

endmodule

// File: src/mpb_msg_counter.sv
// counts complete messages held in an egress queue
// goes up when a last flit is pushed from the bus, down when a
// last flit leaves on the NoC; the NoC side is held off while zero

`timescale 1ns/1ps

module mpb_msg_counter (
  input  logic                      HCLK,
  input  logic                      HRESETn,
  input  logic                      msg_in,   // last flit pushed
  input  logic                      msg_out,  // last flit sent
  output logic [mpb_pkg::LVL_W-1:0] count,
  output logic                      any
);

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      count <= '0;
    end else begin
      case ({msg_in, msg_out})
        2'b10:   count <= count + 1'b1;  // message complete
        2'b01:   count <= count - 1'b1;  // message gone
        default: ;                       // none, or one in one out
      endcase
    end
  end

  assign any = |count;

  // a message can only leave once the counter has seen it arrive
  a_no_underflow : assert property (@(posedge HCLK) disable iff (!HRESETn)
    msg_out |-> any);

endmodule

// File: src/mpb_ahb_fsm.sv
// AHB-Lite slave FSM for one channel
// samples the address phase, then pushes, pops or returns status in
// the data phase with zero wait states
// a push into a full egress queue or a pop from an empty ingress queue
// gets the two cycle ERROR response instead

`timescale 1ns/1ps

module mpb_ahb_fsm (
  input  logic                       HCLK,
  input  logic                       HRESETn,
  input  mpb_pkg::mpb_ahb_req_t      req,
  input  logic [mpb_pkg::FLIT_W-1:0] HWDATA,
  input  mpb_pkg::mpb_status_t       status,
  input  mpb_pkg::mpb_flit_t         in_head,
  input  logic                       in_empty,
  input  logic                       out_full,
  output logic                       out_push,
  output mpb_pkg::mpb_flit_t         out_flit,
  output logic                       in_pop,
  output logic [mpb_pkg::FLIT_W-1:0] HRDATA,
  output logic                       HREADYOUT,
  output logic                       HRESP
);

  typedef enum logic [1:0] {IDLE, DATA, ERR1} state_t;

  state_t                    state;
  state_t                    state_nxt;
  logic [mpb_pkg::OFS_W-1:0] ofs_q;    // word offset of current transfer
  logic                      wr_q;
  logic                      err_q;    // high through both error cycles
  logic [mpb_pkg::OFS_W-1:0] ofs_a;
  logic                      start;
  logic                      push_a;
  logic                      pop_a;
  logic                      full_a;
  logic                      empty_a;
  logic                      err_a;

  ////////////////////////////////////////////////////////////
  // address phase
  ////////////////////////////////////////////////////////////

  assign start  = req.sel && req.trans[1];  // NONSEQ or SEQ
  assign ofs_a  = req.addr[mpb_pkg::CH_BIT-1:2];
  assign push_a = req.write && (ofs_a == mpb_pkg::OFS_DATA || ofs_a == mpb_pkg::OFS_CTRL);
  assign pop_a  = !req.write && (ofs_a == mpb_pkg::OFS_DATA);

  // queue state as it will be in the data phase, counting the
  // push or pop of the transfer finishing now
  assign full_a  = out_full || (out_push && (status.out_level + 1'b1) == mpb_pkg::LVL_FULL);
  assign empty_a = in_empty || (in_pop && (status.in_level - 1'b1) == '0);
  assign err_a   = (push_a && full_a) || (pop_a && empty_a);

  always_comb begin
    state_nxt = IDLE;
    if (state == ERR1)  state_nxt = DATA;   // second error cycle
    else if (start)     state_nxt = err_a ? ERR1 : DATA;
  end

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      state <= IDLE;
      ofs_q <= '0;
      wr_q  <= 1'b0;
      err_q <= 1'b0;
    end else begin
      state <= state_nxt;
      if (state != ERR1) begin           // no sampling while stalled
        err_q <= start && err_a;
        if (start) begin
          ofs_q <= ofs_a;
          wr_q  <= req.write;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // data phase
  ////////////////////////////////////////////////////////////

  assign out_push = (state == DATA) && !err_q && wr_q &&
                    (ofs_q == mpb_pkg::OFS_DATA || ofs_q == mpb_pkg::OFS_CTRL);
  assign in_pop   = (state == DATA) && !err_q && !wr_q && (ofs_q == mpb_pkg::OFS_DATA);

  assign out_flit.data = HWDATA;
  assign out_flit.last = (ofs_q == mpb_pkg::OFS_CTRL);  // control offset closes message

  always_comb begin
    HRDATA = '0;                          // other offsets read zero
    if (state == DATA && !wr_q && !err_q) begin
      if (ofs_q == mpb_pkg::OFS_DATA)      HRDATA = in_head.data;
      else if (ofs_q == mpb_pkg::OFS_CTRL) HRDATA = status;
    end
  end

  assign HREADYOUT = (state != ERR1);
  assign HRESP     = err_q;

  // lookahead lets a data phase through only when its queue can take it
  a_lookahead_safe : assert property (@(posedge HCLK) disable iff (!HRESETn)
    !(out_push && out_full) && !(in_pop && in_empty));

endmodule

// File: src/mpb_endpoint.sv
// one NoC channel of the message passing buffer
// bus FSM in front of an egress and an ingress queue
// egress flits go out only while a complete message is buffered
// ingress flits are accepted whenever there is room

`timescale 1ns/1ps

module mpb_endpoint (
  input  logic                       HCLK,
  input  logic                       HRESETn,
  input  mpb_pkg::mpb_ahb_req_t      req,
  input  logic [mpb_pkg::FLIT_W-1:0] HWDATA,
  output logic [mpb_pkg::FLIT_W-1:0] HRDATA,
  output logic                       HREADYOUT,
  output logic                       HRESP,
  input  mpb_pkg::mpb_flit_t         noc_in,
  input  logic                       noc_in_valid,
  output logic                       noc_in_ready,
  output mpb_pkg::mpb_flit_t         noc_out,
  output logic                       noc_out_valid,
  input  logic                       noc_out_ready
);

  mpb_pkg::mpb_flit_t        in_head;
  mpb_pkg::mpb_flit_t        out_flit;   // from the bus
  mpb_pkg::mpb_status_t      status;
  logic                      in_empty, in_full, in_pop;
  logic                      out_empty, out_full, out_push;
  logic [mpb_pkg::LVL_W-1:0] in_level, out_level, msg_count;
  logic                      msg_any;
  logic                      in_fire, out_fire;

  assign in_fire       = noc_in_valid && noc_in_ready;
  assign out_fire      = noc_out_valid && noc_out_ready;
  assign noc_in_ready  = !in_full;
  assign noc_out_valid = msg_any;    // whole message buffered

  always_comb begin
    status              = '0;
    status.in_level     = in_level;
    status.out_level    = out_level;
    status.out_msgs     = msg_count;
    status.in_head_last = in_head.last && !in_empty;
  end

  mpb_ahb_fsm u_fsm (
    .HCLK, .HRESETn, .req, .HWDATA, .status, .in_head, .in_empty, .out_full,
    .out_push, .out_flit, .in_pop, .HRDATA, .HREADYOUT, .HRESP
  );

  // bus to NoC
  mpb_fifo u_egress (
    .HCLK, .HRESETn, .push(out_push), .push_flit(out_flit), .pop(out_fire),
    .head(noc_out), .empty(out_empty), .full(out_full), .level(out_level)
  );

  // NoC to bus
  mpb_fifo u_ingress (
    .HCLK, .HRESETn, .push(in_fire), .push_flit(noc_in), .pop(in_pop),
    .head(in_head), .empty(in_empty), .full(in_full), .level(in_level)
  );

  mpb_msg_counter u_msgs (
    .HCLK, .HRESETn,
    .msg_in  (out_push && out_flit.last),
    .msg_out (out_fire && noc_out.last),
    .count   (msg_count),
    .any     (msg_any)
  );

  // counted messages always have their flits in the egress queue
  a_msgs_buffered : assert property (@(posedge HCLK) disable iff (!HRESETn)
    msg_any |-> !out_empty);

endmodule

// File: src/mpb.sv
// top of the message passing buffer
// one AHB-Lite slave port shared by CHANNELS NoC endpoints
// the channel comes from address bit CH_BIT, is latched with the
// address phase and steers the response of the data phase

`timescale 1ns/1ps

module mpb (
  input  logic                                          HCLK,
  input  logic                                          HRESETn,
  input  logic                                          HSEL,
  input  logic [mpb_pkg::ADDR_W-1:0]                    HADDR,
  input  logic [mpb_pkg::FLIT_W-1:0]                    HWDATA,
  input  logic                                          HWRITE,
  input  logic [1:0]                                    HTRANS,
  output logic [mpb_pkg::FLIT_W-1:0]                    HRDATA,
  output logic                                          HREADYOUT,
  output logic                                          HRESP,
  input  mpb_pkg::mpb_flit_t [mpb_pkg::CHANNELS-1:0]    noc_in,
  input  logic [mpb_pkg::CHANNELS-1:0]                  noc_in_valid,
  output logic [mpb_pkg::CHANNELS-1:0]                  noc_in_ready,
  output mpb_pkg::mpb_flit_t [mpb_pkg::CHANNELS-1:0]    noc_out,
  output logic [mpb_pkg::CHANNELS-1:0]                  noc_out_valid,
  input  logic [mpb_pkg::CHANNELS-1:0]                  noc_out_ready
);

  logic [mpb_pkg::CH_W-1:0]                            ch_a;       // address phase
  logic [mpb_pkg::CH_W-1:0]                            ch_q;       // data phase
  logic [mpb_pkg::CHANNELS-1:0]                        ch_onehot;
  mpb_pkg::mpb_ahb_req_t [mpb_pkg::CHANNELS-1:0]       ep_req;
  logic [mpb_pkg::CHANNELS-1:0][mpb_pkg::FLIT_W-1:0]   ep_rdata;
  logic [mpb_pkg::CHANNELS-1:0]                        ep_ready;
  logic [mpb_pkg::CHANNELS-1:0]                        ep_resp;

  ////////////////////////////////////////////////////////////
  // channel decode
  ////////////////////////////////////////////////////////////

  assign ch_a      = HADDR[mpb_pkg::CH_BIT +: mpb_pkg::CH_W];
  assign ch_onehot = {{(mpb_pkg::CHANNELS-1){1'b0}}, 1'b1} << ch_a;

  // latch on every accepted address phase
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn)       ch_q <= '0;
    else if (HREADYOUT) ch_q <= ch_a;
  end

  // response of the channel owning the data phase
  assign HRDATA    = ep_rdata[ch_q];
  assign HREADYOUT = ep_ready[ch_q];
  assign HRESP     = ep_resp[ch_q];

  for (genvar c = 0; c < mpb_pkg::CHANNELS; c++) begin : g_ch
    // sel only while the bus is ready, so a stalled phase is not taken twice
    assign ep_req[c].sel   = HSEL && HREADYOUT && ch_onehot[c];
    assign ep_req[c].addr  = HADDR;
    assign ep_req[c].write = HWRITE;
    assign ep_req[c].trans = HTRANS;

    mpb_endpoint u_ep (
      .HCLK, .HRESETn, .req(ep_req[c]), .HWDATA,
      .HRDATA        (ep_rdata[c]),
      .HREADYOUT     (ep_ready[c]),
      .HRESP         (ep_resp[c]),
      .noc_in        (noc_in[c]),
      .noc_in_valid  (noc_in_valid[c]),
      .noc_in_ready  (noc_in_ready[c]),
      .noc_out       (noc_out[c]),
      .noc_out_valid (noc_out_valid[c]),
      .noc_out_ready (noc_out_ready[c])
    );
  end

endmodule

// File: test/mpb_tb.sv
// testbench for the message passing buffer
// builds a table of bus and NoC steps, then walks it in order
// bus transfers are single, with an idle cycle between them
// NoC models drive noc_in and take noc_out with a stall first
// the closing line gives the counts, then the verdict

`timescale 1ns/1ps

module mpb_tb;

  localparam int TIMEOUT = 50;  // cycles per wait loop

  typedef enum logic [2:0] {WR_DATA, WR_LAST, RD_DATA, RD_STAT, NOC_INJ, NOC_EXP} op_t;

  // exp_val is read data, noc_out_valid after a write, or the last bit for NoC rows
  // err marks an ERROR response, or a refused inject
  typedef struct packed {
    op_t         op;
    logic        ch;
    logic [31:0] value;
    logic [31:0] exp_val;
    logic        err;
  } step_t;

  logic                                             HCLK;
  logic                                             HRESETn;
  logic                                             HSEL;
  logic [mpb_pkg::ADDR_W-1:0]                       HADDR;
  logic [mpb_pkg::FLIT_W-1:0]                       HWDATA;
  logic                                             HWRITE;
  logic [1:0]                                       HTRANS;
  logic [mpb_pkg::FLIT_W-1:0]                       HRDATA;
  logic                                             HREADYOUT;
  logic                                             HRESP;
  mpb_pkg::mpb_flit_t [mpb_pkg::CHANNELS-1:0]       noc_in;
  logic [mpb_pkg::CHANNELS-1:0]                     noc_in_valid;
  logic [mpb_pkg::CHANNELS-1:0]                     noc_in_ready;
  mpb_pkg::mpb_flit_t [mpb_pkg::CHANNELS-1:0]       noc_out;
  logic [mpb_pkg::CHANNELS-1:0]                     noc_out_valid;
  logic [mpb_pkg::CHANNELS-1:0]                     noc_out_ready;

  step_t  steps[$];
  integer seed;
  int     checks;
  int     mismatches;
  int     failures;     // timeouts and protocol faults

  mpb uut (
    .HCLK, .HRESETn, .HSEL, .HADDR, .HWDATA, .HWRITE, .HTRANS,
    .HRDATA, .HREADYOUT, .HRESP,
    .noc_in, .noc_in_valid, .noc_in_ready, .noc_out, .noc_out_valid, .noc_out_ready
  );

  always #2 HCLK = ~HCLK;  // 4 ns period

  // channel 1 never gets egress traffic
  always @(negedge HCLK) begin
    if (HRESETn && noc_out_valid[1]) begin
      $display("channel 1 raised noc_out_valid with no message written at %0t", $time);
      failures++;
    end
  end

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  task automatic check(input logic [31:0] got, input logic [31:0] exp_val, input string what);
    checks++;
    if (got !== exp_val) begin
      $display("mismatch at %0t ns: %s, got %h expected %h", $time, what, got, exp_val);
      mismatches++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timed out waiting for %s at %0t", what, $time);
    failures++;
  endtask

  // field order of the status word, in_level in the low nibble
  function automatic logic [31:0] status_word(input int in_lvl, input int out_lvl,
                                              input int msgs, input logic head_last);
    return (32'(head_last) << 12) | (32'(msgs) << 8) | (32'(out_lvl) << 4) | 32'(in_lvl);
  endfunction

  task automatic add_step(input op_t op, input logic ch, input logic [31:0] value,
                          input logic [31:0] exp_val, input logic err);
    steps.push_back(step_t'{op, ch, value, exp_val, err});
  endtask

  // one single transfer, returns read data and whether ERROR came back
  task automatic bus_transfer(input logic ch, input logic [1:0] ofs, input logic wr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic resp_err);
    int   n;
    logic stalled;
    n       = 0;
    stalled = 1'b0;
    @(posedge HCLK);
    HSEL   <= 1'b1;
    HTRANS <= 2'b10;                       // NONSEQ
    HWRITE <= wr;
    HADDR  <= {27'd0, ch, ofs, 2'b00};
    @(posedge HCLK);                       // address phase taken
    HSEL   <= 1'b0;
    HTRANS <= 2'b00;
    HWDATA <= wdata;
    @(negedge HCLK);
    while (!HREADYOUT && n < TIMEOUT) begin
      stalled = 1'b1;
      if (!HRESP) begin
        $display("wait state without HRESP high at %0t", $time);
        failures++;
      end
      n++;
      @(negedge HCLK);
    end
    if (!HREADYOUT) report_timeout("HREADYOUT");
    if (n > 1) begin
      $display("ERROR response held HREADYOUT low for %0d cycles at %0t", n, $time);
      failures++;
    end
    if (HRESP && !stalled) begin
      $display("HRESP high without the first ERROR cycle at %0t", $time);
      failures++;
    end
    rdata    = HRDATA;
    resp_err = HRESP && stalled;
    @(posedge HCLK);                       // data phase ends here
  endtask

  task automatic noc_inject(input logic ch, input logic [31:0] data, input logic last,
                            input logic refuse);
    int                 n;
    mpb_pkg::mpb_flit_t f;
    n      = 0;
    f.data = data;
    f.last = last;
    @(posedge HCLK);
    noc_in[ch]       <= f;
    noc_in_valid[ch] <= 1'b1;
    if (refuse) begin
      repeat (3) begin                     // full queue keeps ready low
        @(negedge HCLK);
        check(32'(noc_in_ready[ch]), 32'd0, "noc_in_ready with full ingress");
      end
    end else begin
      @(negedge HCLK);
      while (!noc_in_ready[ch] && n < TIMEOUT) begin
        n++;
        @(negedge HCLK);
      end
      if (!noc_in_ready[ch]) report_timeout("noc_in_ready");
    end
    @(posedge HCLK);                       // handshake edge
    noc_in_valid[ch] <= 1'b0;
  endtask

  task automatic noc_expect(input logic ch, input logic [31:0] data, input logic last);
    int n;
    n = 0;
    @(negedge HCLK);
    while (!noc_out_valid[ch] && n < TIMEOUT) begin
      n++;
      @(negedge HCLK);
    end
    if (!noc_out_valid[ch]) begin
      report_timeout("noc_out_valid");
    end else begin
      repeat (3) begin                     // ready low, flit must hold
        check(noc_out[ch].data, data, "noc_out data");
        check(32'(noc_out[ch].last), 32'(last), "noc_out last");
        check(32'(noc_out_valid[ch]), 32'd1, "noc_out_valid under back-pressure");
        @(negedge HCLK);
      end
      @(posedge HCLK);
      noc_out_ready[ch] <= 1'b1;
      @(posedge HCLK);                     // flit taken
      noc_out_ready[ch] <= 1'b0;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus table
  ////////////////////////////////////////////////////////////

  task automatic build_table();
    logic [31:0] d [9];
    int          k;
    // three flit message on channel 0
    add_step(WR_DATA, 1'b0, 32'hA000_0001, 32'd0, 1'b0);
    add_step(WR_DATA, 1'b0, 32'hA000_0002, 32'd0, 1'b0);
    add_step(RD_STAT, 1'b0, 32'd0, status_word(0, 2, 0, 1'b0), 1'b0);
    add_step(WR_LAST, 1'b0, 32'hA000_0003, 32'd1, 1'b0);   // valid rises now
    add_step(RD_STAT, 1'b0, 32'd0, status_word(0, 3, 1, 1'b0), 1'b0);
    add_step(RD_STAT, 1'b1, 32'd0, 32'd0, 1'b0);            // channel 1 untouched
    add_step(NOC_EXP, 1'b0, 32'hA000_0001, 32'd0, 1'b0);
    add_step(NOC_EXP, 1'b0, 32'hA000_0002, 32'd0, 1'b0);
    add_step(NOC_EXP, 1'b0, 32'hA000_0003, 32'd1, 1'b0);
    add_step(RD_STAT, 1'b0, 32'd0, 32'd0, 1'b0);
    // two flits into channel 1 ingress
    add_step(NOC_INJ, 1'b1, 32'hB000_0001, 32'd0, 1'b0);
    add_step(NOC_INJ, 1'b1, 32'hB000_0002, 32'd1, 1'b0);
    add_step(RD_STAT, 1'b1, 32'd0, status_word(2, 0, 0, 1'b0), 1'b0);
    add_step(RD_DATA, 1'b1, 32'd0, 32'hB000_0001, 1'b0);
    add_step(RD_STAT, 1'b1, 32'd0, status_word(1, 0, 0, 1'b1), 1'b0);
    add_step(RD_DATA, 1'b1, 32'd0, 32'hB000_0002, 1'b0);
    add_step(RD_STAT, 1'b1, 32'd0, 32'd0, 1'b0);
    add_step(RD_STAT, 1'b0, 32'd0, 32'd0, 1'b0);
    // error cases
    add_step(RD_DATA, 1'b1, 32'd0, 32'd0, 1'b1);            // empty ingress
    for (k = 0; k < 9; k++) d[k] = $random(seed);
    for (k = 0; k < 7; k++) add_step(WR_DATA, 1'b0, d[k], 32'd0, 1'b0);
    add_step(WR_LAST, 1'b0, d[7], 32'd1, 1'b0);             // queue now full
    add_step(WR_DATA, 1'b0, d[8], 32'd1, 1'b1);             // dropped
    add_step(RD_STAT, 1'b0, 32'd0, status_word(0, 8, 1, 1'b0), 1'b0);
    add_step(RD_STAT, 1'b1, 32'd0, 32'd0, 1'b0);
    for (k = 0; k < 8; k++) add_step(NOC_EXP, 1'b0, d[k], 32'(k == 7), 1'b0);
    // fill channel 1 ingress, ninth is refused
    for (k = 0; k < 9; k++) d[k] = $random(seed);
    for (k = 0; k < 8; k++) add_step(NOC_INJ, 1'b1, d[k], 32'(k == 7), 1'b0);
    add_step(NOC_INJ, 1'b1, d[8], 32'd0, 1'b1);
    add_step(RD_STAT, 1'b1, 32'd0, status_word(8, 0, 0, 1'b0), 1'b0);
    for (k = 0; k < 8; k++) add_step(RD_DATA, 1'b1, 32'd0, d[k], 1'b0);
    add_step(RD_STAT, 1'b1, 32'd0, 32'd0, 1'b0);
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    step_t       row;
    logic [31:0] rdata;
    logic        resp_err;
    HCLK          = 1'b0;
    HRESETn       = 1'b0;
    HSEL          = 1'b0;
    HADDR         = '0;
    HWDATA        = '0;
    HWRITE        = 1'b0;
    HTRANS        = 2'b00;
    noc_in        = '0;
    noc_in_valid  = '0;
    noc_out_ready = '0;
    seed          = 32'h8745;
    checks        = 0;
    mismatches    = 0;
    failures      = 0;
    build_table();
    repeat (5) @(posedge HCLK);
    HRESETn <= 1'b1;
    @(negedge HCLK);
    check(32'(HREADYOUT), 32'd1, "HREADYOUT after reset");
    check(32'(HRESP), 32'd0, "HRESP after reset");
    check(32'(noc_out_valid), 32'd0, "noc_out_valid after reset");
    check(32'(noc_in_ready), 32'd3, "noc_in_ready after reset");
    foreach (steps[i]) begin
      row = steps[i];
      case (row.op)
        WR_DATA, WR_LAST: begin
          bus_transfer(row.ch, (row.op == WR_LAST) ? mpb_pkg::OFS_CTRL : mpb_pkg::OFS_DATA,
                       1'b1, row.value, rdata, resp_err);
          check(32'(resp_err), 32'(row.err), $sformatf("step %0d write response", i));
          @(negedge HCLK);
          check(32'(noc_out_valid[row.ch]), row.exp_val,
                $sformatf("step %0d noc_out_valid after write", i));
        end
        RD_DATA, RD_STAT: begin
          bus_transfer(row.ch, (row.op == RD_STAT) ? mpb_pkg::OFS_CTRL : mpb_pkg::OFS_DATA,
                       1'b0, 32'd0, rdata, resp_err);
          check(32'(resp_err), 32'(row.err), $sformatf("step %0d read response", i));
          if (!row.err) check(rdata, row.exp_val, $sformatf("step %0d read data", i));
        end
        NOC_INJ: noc_inject(row.ch, row.value, row.exp_val[0], row.err);
        NOC_EXP: noc_expect(row.ch, row.value, row.exp_val[0]);
        default: ;
      endcase
    end
    repeat (2) @(posedge HCLK);
    $display("checks %0d, mismatches %0d, other failures %0d", checks, mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: all.f
src/mpb_pkg.sv
src/mpb_fifo.sv
src/mpb_msg_counter.sv
src/mpb_ahb_fsm.sv
src/mpb_endpoint.sv
src/mpb.sv
test/mpb_tb.sv

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" &&
verilator --binary --timing --top-module mpb_tb -f all.f -o mpb_sim &&
./obj_dir/mpb_sim | tee /dev/stderr | grep -x '>>> PASS' > /dev/null &&
echo "simulation passed" ||
{ echo "simulation failed" >&2; exit 1; }
